// File: verilog/cpu_types_pkg.sv
`default_nettype none

package cpu_types_pkg;

  // data and address word
  typedef logic [31:0] word_t;

  // core count, round-robin bit is one bit wide
  localparam int CPUS = 2;

  // ram wait states before the access cycle
  localparam int RAM_LATENCY = 2;

  // ram depth in words, upper address bits ignored
  localparam int RAM_WORDS = 256;

  // word index width inside the ram
  localparam int RAM_INDEX_W = $clog2(RAM_WORDS);

  // ram handshake state seen by the controller
  typedef enum logic [1:0]
  {
    FREE,
    BUSY,
    ACCESS,
    ERROR
  } ramstate_t;

  // bus arbitration and coherence states
  typedef enum logic [3:0]
  {
    IDLE,
    INSTRUCTION,
    STORE_1,
    STORE_2,
    LOAD_1,
    LOAD_2,
    ARBITRATE,
    SNOOP,
    CACHE_1,
    CACHE_2
  } bus_state_t;

endpackage

`default_nettype wire

// File: verilog/cache_control_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cache_control_if;
  import cpu_types_pkg::*;

  // requests from the cores, one bit per core
  logic [CPUS-1:0] iREN;
  logic [CPUS-1:0] dREN;
  logic [CPUS-1:0] dWEN;
  word_t [CPUS-1:0] iaddr;
  word_t [CPUS-1:0] daddr;
  word_t [CPUS-1:0] dstore;

  // coherence requests from the caches
  logic [CPUS-1:0] ccwrite;
  logic [CPUS-1:0] cctrans;

  // replies from the bus controller
  logic [CPUS-1:0] iwait;
  logic [CPUS-1:0] dwait;
  word_t [CPUS-1:0] iload;
  word_t [CPUS-1:0] dload;

  // coherence replies, snoop address is the requester's daddr
  logic [CPUS-1:0] ccwait;
  logic [CPUS-1:0] ccinv;
  word_t [CPUS-1:0] ccsnoopaddr;

  // bus controller side
  modport cc
  (
    input  iREN, dREN, dWEN, iaddr, daddr, dstore,
    input  ccwrite, cctrans,
    output iwait, dwait, iload, dload,
    output ccwait, ccinv, ccsnoopaddr
  );

  // core and cache side
  modport core
  (
    output iREN, dREN, dWEN, iaddr, daddr, dstore,
    output ccwrite, cctrans,
    input  iwait, dwait, iload, dload,
    input  ccwait, ccinv, ccsnoopaddr
  );

endinterface

`default_nettype wire

// File: verilog/ram_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ram_if;
  import cpu_types_pkg::*;

  // one word per request, held until ACCESS
  logic ramREN;
  logic ramWEN;
  word_t ramaddr;
  word_t ramstore;

  // read data and handshake state back from the ram
  word_t ramload;
  ramstate_t ramstate;

  modport controller
  (
    output ramREN, ramWEN, ramaddr, ramstore,
    input  ramload, ramstate
  );

  modport ram
  (
    input  ramREN, ramWEN, ramaddr, ramstore,
    output ramload, ramstate
  );

endinterface

`default_nettype wire

// File: verilog/memory_control.sv
`timescale 1ns/1ps
`default_nettype none

module memory_control
(
  input logic CLK,
  input logic nRST,
  cache_control_if.cc ccif,
  ram_if.controller ramif
);
  import cpu_types_pkg::*;

  bus_state_t state, next_state;

  // least recently served core wins ties
  logic cpu_lru, next_cpu_lru;

  // requester of a read miss and the core it snoops
  logic snooper, next_snooper;
  logic snoopy, next_snoopy;

  // per request kind, the core that gets the grant
  logic i_sel;
  logic st_sel;
  logic rd_sel;
  logic tr_sel;
  logic ram_done;

  assign i_sel = ccif.iREN[cpu_lru] ? cpu_lru : ~cpu_lru;
  assign st_sel = ccif.dWEN[cpu_lru] ? cpu_lru : ~cpu_lru;
  assign rd_sel = ccif.dREN[cpu_lru] ? cpu_lru : ~cpu_lru;
  assign tr_sel = ccif.cctrans[cpu_lru] ? cpu_lru : ~cpu_lru;
  assign ram_done = (ramif.ramstate == ACCESS);

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      state <= IDLE;
      cpu_lru <= 1'b0;
      snooper <= 1'b0;
      snoopy <= 1'b1;
    end
    else
    begin
      state <= next_state;
      cpu_lru <= next_cpu_lru;
      snooper <= next_snooper;
      snoopy <= next_snoopy;
    end
  end

  // next state
  always_comb
  begin
    next_state = state;
    next_snooper = snooper;
    next_snoopy = snoopy;
    case (state)
      IDLE:
      begin
        // stores drain first
        if (|ccif.dWEN)
          next_state = STORE_1;
        else if (|ccif.cctrans || |ccif.dREN)
          next_state = ARBITRATE;
        else if (|ccif.iREN)
          next_state = INSTRUCTION;
      end
      INSTRUCTION:
      begin
        if (ram_done || !(|ccif.iREN))
          next_state = IDLE;
      end
      STORE_1:
      begin
        if (!(|ccif.dWEN))
          next_state = IDLE;
        else if (ram_done)
          next_state = STORE_2;
      end
      STORE_2:
      begin
        if (ram_done || !(|ccif.dWEN))
          next_state = IDLE;
      end
      ARBITRATE:
      begin
        // a read picks its snoop pair, an upgrade finishes here
        if (|ccif.dREN)
        begin
          next_state = SNOOP;
          next_snooper = rd_sel;
          next_snoopy = ~rd_sel;
        end
        else
          next_state = IDLE;
      end
      SNOOP:
      begin
        // other cache answers with cctrans on a hit
        if (ccif.cctrans[snoopy])
          next_state = CACHE_1;
        else
          next_state = LOAD_1;
      end
      CACHE_1:
        if (ram_done) next_state = CACHE_2;
      CACHE_2:
        if (ram_done) next_state = IDLE;
      LOAD_1:
        if (ram_done) next_state = LOAD_2;
      LOAD_2:
        if (ram_done) next_state = IDLE;
      default:
        next_state = IDLE;
    endcase
  end

  // outputs and round-robin update
  always_comb
  begin
    ccif.iwait = '1;
    ccif.dwait = '1;
    ccif.iload = '0;
    ccif.dload = '0;
    ccif.ccwait = '0;
    ccif.ccinv = '0;
    ccif.ccsnoopaddr = '0;
    ramif.ramREN = 1'b0;
    ramif.ramWEN = 1'b0;
    ramif.ramaddr = '0;
    ramif.ramstore = '0;
    next_cpu_lru = cpu_lru;
    case (state)
      INSTRUCTION:
      begin
        if (|ccif.iREN)
        begin
          ramif.ramREN = 1'b1;
          ramif.ramaddr = ccif.iaddr[i_sel];
          ccif.iload[i_sel] = ramif.ramload;
          if (ram_done)
          begin
            ccif.iwait[i_sel] = 1'b0;
            next_cpu_lru = ~i_sel;
          end
        end
      end
      STORE_1, STORE_2:
      begin
        if (|ccif.dWEN)
        begin
          ramif.ramWEN = 1'b1;
          ramif.ramaddr = ccif.daddr[st_sel];
          ramif.ramstore = ccif.dstore[st_sel];
          // hold off the other cache while the block is written
          ccif.ccwait[~st_sel] = 1'b1;
          if (ram_done)
          begin
            ccif.dwait[st_sel] = 1'b0;
            // grant ends after the second word
            if (state == STORE_2)
              next_cpu_lru = ~st_sel;
          end
        end
      end
      ARBITRATE:
      begin
        if (|ccif.dREN)
        begin
          ccif.ccwait[~rd_sel] = 1'b1;
          next_cpu_lru = ~rd_sel;
        end
        else if (|ccif.cctrans)
        begin
          // shared line written, invalidate the other copy
          ccif.ccinv[~tr_sel] = 1'b1;
          ccif.ccsnoopaddr[~tr_sel] = ccif.daddr[tr_sel];
          ccif.dwait[tr_sel] = 1'b0;
          next_cpu_lru = ~tr_sel;
        end
      end
      SNOOP:
      begin
        ccif.ccwait[snoopy] = 1'b1;
        ccif.ccsnoopaddr[snoopy] = ccif.daddr[snooper];
      end
      CACHE_1, CACHE_2:
      begin
        ccif.ccwait[snoopy] = 1'b1;
        ccif.ccsnoopaddr[snoopy] = ccif.daddr[snooper];
        // cache to cache transfer, ram written back in the same word
        ccif.dload[snooper] = ccif.dstore[snoopy];
        ccif.ccinv[snoopy] = ccif.ccwrite[snooper];
        ramif.ramWEN = 1'b1;
        ramif.ramaddr = ccif.daddr[snooper];
        ramif.ramstore = ccif.dstore[snoopy];
        if (ram_done)
        begin
          ccif.dwait[snooper] = 1'b0;
          ccif.dwait[snoopy] = 1'b0;
        end
      end
      LOAD_1, LOAD_2:
      begin
        ccif.ccsnoopaddr[snoopy] = ccif.daddr[snooper];
        ccif.ccinv[snoopy] = ccif.ccwrite[snooper];
        ramif.ramREN = 1'b1;
        ramif.ramaddr = ccif.daddr[snooper];
        ccif.dload[snooper] = ramif.ramload;
        if (ram_done)
          ccif.dwait[snooper] = 1'b0;
      end
      default:
      begin
      end
    endcase
  end

  // one ram operation at a time
  a_ram_one_op: assert property (@(posedge CLK) disable iff (!nRST)
    !(ramif.ramREN && ramif.ramWEN));

  // only one fetch granted per cycle
  a_one_iwait: assert property (@(posedge CLK) disable iff (!nRST)
    ccif.iwait != 2'b00);

  // data words complete only on a ram access or an upgrade
  a_dwait_src: assert property (@(posedge CLK) disable iff (!nRST)
    (ccif.dwait != 2'b11) |-> (ram_done || state == ARBITRATE));

endmodule

`default_nettype wire

// File: verilog/ram_model.sv
`timescale 1ns/1ps
`default_nettype none

module ram_model
(
  input logic CLK,
  input logic nRST,
  ram_if.ram ramif
);
  import cpu_types_pkg::*;

  word_t mem [RAM_WORDS];

  logic [RAM_INDEX_W-1:0] index;
  logic [$clog2(RAM_LATENCY+1)-1:0] wait_count;
  logic request;
  logic last_req;
  word_t last_addr;

  // new word when the address moved or nothing was asked last cycle
  logic fresh;
  logic access;

  // byte offset dropped, upper bits ignored
  assign index = ramif.ramaddr[RAM_INDEX_W+1:2];
  assign request = ramif.ramREN | ramif.ramWEN;
  assign fresh = !last_req || (ramif.ramaddr != last_addr);
  assign access = request && !fresh && (wait_count == RAM_LATENCY);

  always_comb
  begin
    if (!request)
      ramif.ramstate = FREE;
    else if (access)
      ramif.ramstate = ACCESS;
    else
      ramif.ramstate = BUSY;
  end

  // wait-state counter
  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      wait_count <= '0;
      last_req <= 1'b0;
    end
    else
    begin
      last_req <= request;
      if (!request || access)
        wait_count <= '0;
      else if (fresh)
        wait_count <= 1;
      else
        wait_count <= wait_count + 1'b1;
    end
  end

  always_ff @(posedge CLK)
  begin
    last_addr <= ramif.ramaddr;
    // write lands in the access cycle
    if (access && ramif.ramWEN)
      mem[index] <= ramif.ramstore;
  end

  assign ramif.ramload = mem[index];

  a_no_rw: assert property (@(posedge CLK) disable iff (!nRST)
    !(ramif.ramREN && ramif.ramWEN));

  // controller keeps the word's address while it waits
  a_addr_stable: assert property (@(posedge CLK) disable iff (!nRST)
    (ramif.ramstate == BUSY) |=>
      (!(ramif.ramREN || ramif.ramWEN) || $stable(ramif.ramaddr)));

endmodule

`default_nettype wire

// File: verilog/coherent_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module coherent_bus_top
(
  input logic CLK,
  input logic nRST,
  // core requests
  input logic [cpu_types_pkg::CPUS-1:0] iren,
  input logic [cpu_types_pkg::CPUS-1:0] dren,
  input logic [cpu_types_pkg::CPUS-1:0] dwen,
  input logic [cpu_types_pkg::CPUS-1:0] ccwrite,
  input logic [cpu_types_pkg::CPUS-1:0] cctrans,
  input cpu_types_pkg::word_t [cpu_types_pkg::CPUS-1:0] iaddr,
  input cpu_types_pkg::word_t [cpu_types_pkg::CPUS-1:0] daddr,
  input cpu_types_pkg::word_t [cpu_types_pkg::CPUS-1:0] dstore,
  // controller replies
  output logic [cpu_types_pkg::CPUS-1:0] iwait,
  output logic [cpu_types_pkg::CPUS-1:0] dwait,
  output logic [cpu_types_pkg::CPUS-1:0] ccwait,
  output logic [cpu_types_pkg::CPUS-1:0] ccinv,
  output cpu_types_pkg::word_t [cpu_types_pkg::CPUS-1:0] iload,
  output cpu_types_pkg::word_t [cpu_types_pkg::CPUS-1:0] dload,
  output cpu_types_pkg::word_t [cpu_types_pkg::CPUS-1:0] ccsnoopaddr
);

  cache_control_if ccif ();
  ram_if ramif ();

  // core side of the bus from the plain ports
  assign ccif.iREN = iren;
  assign ccif.dREN = dren;
  assign ccif.dWEN = dwen;
  assign ccif.ccwrite = ccwrite;
  assign ccif.cctrans = cctrans;
  assign ccif.iaddr = iaddr;
  assign ccif.daddr = daddr;
  assign ccif.dstore = dstore;

  assign iwait = ccif.iwait;
  assign dwait = ccif.dwait;
  assign ccwait = ccif.ccwait;
  assign ccinv = ccif.ccinv;
  assign iload = ccif.iload;
  assign dload = ccif.dload;
  assign ccsnoopaddr = ccif.ccsnoopaddr;

  // arbiter and coherence FSM
  memory_control u_memory_control
  (
    .CLK   (CLK),
    .nRST  (nRST),
    .ccif  (ccif.cc),
    .ramif (ramif.controller)
  );

  // shared word-wide ram
  ram_model u_ram_model
  (
    .CLK   (CLK),
    .nRST  (nRST),
    .ramif (ramif.ram)
  );

endmodule

`default_nettype wire

// File: verification/coherent_bus_tb.sv
`timescale 1ns/1ps
`default_nettype none

module coherent_bus_tb;
  import cpu_types_pkg::*;

  // one transaction line from the data file
  typedef struct
  {
    int kind;
    int core;
    word_t addr;
    word_t d0;
    word_t d1;
    word_t e0;
    word_t e1;
    int flag;
    word_t addr2;
  } test_t;

  logic CLK = 1'b0;
  logic nRST;
  logic [CPUS-1:0] iren, dren, dwen, ccwrite, cctrans;
  word_t [CPUS-1:0] iaddr, daddr, dstore;
  logic [CPUS-1:0] iwait, dwait, ccwait, ccinv;
  word_t [CPUS-1:0] iload, dload, ccsnoopaddr;

  test_t tests[$];
  int served[$];
  int errors = 0;
  bit loaded = 0;
  // set while a store block is still on the bus
  bit store_busy = 0;

  always #5 CLK = ~CLK;

  coherent_bus_top uut
  (
    .CLK(CLK), .nRST(nRST),
    .iren(iren), .dren(dren), .dwen(dwen), .ccwrite(ccwrite), .cctrans(cctrans),
    .iaddr(iaddr), .daddr(daddr), .dstore(dstore),
    .iwait(iwait), .dwait(dwait), .ccwait(ccwait), .ccinv(ccinv),
    .iload(iload), .dload(dload), .ccsnoopaddr(ccsnoopaddr)
  );

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act)
    begin
      $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  // inputs change just after the rising edge
  task automatic next_edge();
    @(posedge CLK);
    #1;
  endtask

  // returns at the falling edge of the cycle where the wait is low
  task automatic wait_word(input int c, input bit data, output word_t got, output int n);
    bit done;
    done = 0;
    n = 0;
    got = '0;
    while (!done)
    begin
      @(negedge CLK);
      n++;
      if (data ? !dwait[c] : !iwait[c])
      begin
        got = data ? dload[c] : iload[c];
        done = 1;
      end
      else if (n > 40)
      begin
        $display("timeout: core %0d %s wait never went low", c, data ? "data" : "fetch");
        errors++;
        done = 1;
      end
    end
  endtask

  task automatic fetch_word(input int c, input word_t a, input word_t exp);
    word_t got;
    int n;
    iren[c] = 1'b1;
    iaddr[c] = a;
    wait_word(c, 0, got, n);
    check_word($sformatf("iload[%0d]", c), exp, got);
    // a pending store must finish before any fetch
    check_bit("store still pending at fetch", 1'b0, store_busy);
    served.push_back(c);
    next_edge();
    iren[c] = 1'b0;
  endtask

  task automatic store_block(input int c, input word_t a, input word_t w0, input word_t w1);
    word_t got;
    int n;
    store_busy = 1;
    dwen[c] = 1'b1;
    daddr[c] = a;
    dstore[c] = w0;
    wait_word(c, 1, got, n);
    check_bit($sformatf("ccwait[%0d]", 1 - c), 1'b1, ccwait[1 - c]);
    next_edge();
    daddr[c] = a + 4;
    dstore[c] = w1;
    wait_word(c, 1, got, n);
    store_busy = 0;
    next_edge();
    dwen[c] = 1'b0;
  endtask

  // read miss where the other cache may supply the block
  task automatic load_block(input test_t t, input bit hit);
    word_t got;
    int n;
    int o;
    o = 1 - t.core;
    dren[t.core] = 1'b1;
    daddr[t.core] = t.addr;
    ccwrite[t.core] = t.flag[0];
    if (hit)
    begin
      // answer in SNOOP after IDLE and ARBITRATE
      next_edge();
      next_edge();
      cctrans[o] = 1'b1;
      dstore[o] = t.d0;
    end
    for (int w = 0; w < 2; w++)
    begin
      wait_word(t.core, 1, got, n);
      check_word($sformatf("dload[%0d]", t.core), w ? t.e1 : t.e0, got);
      check_word($sformatf("ccsnoopaddr[%0d]", o), daddr[t.core], ccsnoopaddr[o]);
      check_bit($sformatf("ccinv[%0d]", o), t.flag[0], ccinv[o]);
      if (hit)
        check_bit($sformatf("dwait[%0d]", o), 1'b0, dwait[o]);
      next_edge();
      daddr[t.core] = t.addr + 4;
      dstore[o] = t.d1;
    end
    dren[t.core] = 1'b0;
    ccwrite[t.core] = 1'b0;
    cctrans[o] = 1'b0;
  endtask

  // shared write hit turned into an invalidation
  task automatic upgrade_line(input test_t t);
    word_t got;
    int n;
    int o;
    o = 1 - t.core;
    cctrans[t.core] = 1'b1;
    daddr[t.core] = t.addr;
    wait_word(t.core, 1, got, n);
    check_word("upgrade cycles", 32'd2, word_t'(n));
    check_bit($sformatf("ccinv[%0d]", o), 1'b1, ccinv[o]);
    check_word($sformatf("ccsnoopaddr[%0d]", o), t.addr, ccsnoopaddr[o]);
    check_bit("ramREN", 1'b0, uut.ramif.ramREN);
    check_bit("ramWEN", 1'b0, uut.ramif.ramWEN);
    next_edge();
    cctrans[t.core] = 1'b0;
  endtask

  // watchdog sized from the number of test lines
  initial
  begin
    wait (loaded);
    repeat (tests.size() * 40 + 3) @(posedge CLK);
    $display("timeout: test run did not finish in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    int fd;
    int cnt;
    string line;
    test_t t;
    void'($urandom(32'hcbcb));
    nRST = 1'b0;
    iren = '0;
    dren = '0;
    dwen = '0;
    ccwrite = '0;
    cctrans = '0;
    iaddr = '0;
    daddr = '0;
    dstore = '0;
    fd = $fopen("verification/bus_tests.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the test file");
      $display("Simulation finished: FAIL");
      $finish;
    end
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        if (line.len() > 1 && line[0] != "#")
        begin
          cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h", t.kind, t.core, t.addr,
                        t.d0, t.d1, t.e0, t.e1, t.flag, t.addr2);
          if (cnt == 9)
            tests.push_back(t);
          else
          begin
            $display("malformed line in the test file");
            errors++;
          end
        end
      end
      $fclose(fd);
      if (tests.size() == 0)
      begin
        $display("no transactions found in the test file");
        errors++;
      end
      loaded = 1;
      repeat (3) @(posedge CLK);
      #1;
      nRST = 1'b1;
      // idle bus straight after reset
      @(negedge CLK);
      check_word("iwait", 32'd3, word_t'(iwait));
      check_word("dwait", 32'd3, word_t'(dwait));
      check_word("ccinv", 32'd0, word_t'(ccinv));
      check_word("ccwait", 32'd0, word_t'(ccwait));
      next_edge();
      foreach (tests[i])
      begin
        t = tests[i];
        case (t.kind)
          1: fetch_word(t.core, t.addr, t.e0);
          2: store_block(t.core, t.addr, t.d0, t.d1);
          3: load_block(t, 0);
          4: load_block(t, 1);
          5: upgrade_line(t);
          6:
          begin
            served.delete();
            fork
              fetch_word(0, t.addr, t.e0);
              fetch_word(1, t.addr2, t.e1);
            join
            check_word("first served core", word_t'(t.core), word_t'(served[0]));
          end
          7:
          begin
            fork
              store_block(t.core, t.addr, t.d0, t.d1);
              fetch_word(1 - t.core, t.addr2, t.e0);
            join
          end
          default:
          begin
            $display("unknown transaction kind %0d on test line %0d", t.kind, i);
            errors++;
          end
        endcase
        repeat ($urandom_range(0, 3)) next_edge();
      end
      $display("tests run: %0d, errors: %0d", tests.size(), errors);
      if (errors == 0)
        $display("Simulation finished: PASS");
      else
        $display("Simulation finished: FAIL");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verification/bus_tests.txt
# kind core addr data0 data1 exp0 exp1 ccwrite addr2, all hex
# kind 1 fetch, 2 store, 3 load, 4 snoop load, 5 upgrade, 6 dual fetch, 7 store and fetch
2 0 40 11111111 22222222 0 0 0 0
3 1 40 0 0 11111111 22222222 0 0
1 0 40 0 0 11111111 0 0 0
2 1 80 a0a0a0a0 b0b0b0b0 0 0 0 0
4 0 80 cafe0001 cafe0002 cafe0001 cafe0002 1 0
3 1 80 0 0 cafe0001 cafe0002 0 0
5 1 80 0 0 0 0 0 0
2 0 100 12345678 9abcdef0 0 0 0 0
2 1 200 0f0f0f0f f0f0f0f0 0 0 0 0
6 0 100 0 0 12345678 0f0f0f0f 0 200
1 0 104 0 0 9abcdef0 0 0 0
6 1 104 0 0 9abcdef0 f0f0f0f0 0 204
7 0 300 11223344 55667788 11111111 0 0 40
3 1 300 0 0 11223344 55667788 1 0
4 1 300 deadbeef feedface deadbeef feedface 0 0
3 0 300 0 0 deadbeef feedface 0 0
5 0 40 0 0 0 0 0 0
3 0 40 0 0 11111111 22222222 0 0

// File: Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert
TOP       := coherent_bus_tb
FILELIST  := project.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Simulation finished: PASS

SRCS := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o V$(TOP)

run: $(BIN) verification/bus_tests.txt
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: project.f
verilog/cpu_types_pkg.sv
verilog/cache_control_if.sv
verilog/ram_if.sv
verilog/memory_control.sv
verilog/ram_model.sv
verilog/coherent_bus_top.sv
verification/coherent_bus_tb.sv
